// File: csr_pkg.sv
package csr_pkg;

    localparam int xlen = 32;

    // low address field of the machine CSRs, payload bits 4:0
    typedef enum logic [4:0] {
        mcsr_status   = 5'h00,
        mcsr_isa      = 5'h01,
        mcsr_ie       = 5'h04,
        mcsr_tvec     = 5'h05,
        mcsr_scratch  = 5'h10,
        mcsr_epc      = 5'h11,
        mcsr_cause    = 5'h12,
        mcsr_tval     = 5'h13,
        mcsr_ip       = 5'h14,
        mcsr_cycle    = 5'h18,
        mcsr_cycleh   = 5'h19,
        mcsr_instret  = 5'h1a,
        mcsr_instreth = 5'h1b,
        mcsr_hartid   = 5'h1f
    } csr_addr_e;

    typedef enum logic [1:0] {
        class_std     = 2'b00, // mstatus .. mip
        class_counter = 2'b10  // mcycle, minstret
    } csr_class_e;

    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_rw   = 2'd1,
        op_rs   = 2'd2,
        op_rc   = 2'd3
    } csr_op_e;

    typedef enum logic [1:0] {
        fun_ecall  = 2'd0,
        fun_ebreak = 2'd1,
        fun_ret    = 2'd2
    } sys_fun_e;

    typedef enum logic [1:0] {
        unit_none = 2'd0, // no valid instruction
        unit_csr  = 2'd1,
        unit_lsu  = 2'd2,
        unit_alu  = 2'd3
    } unit_e;

    typedef enum logic [1:0] {
        imiscon_none      = 2'd0,
        imiscon_illegal   = 2'd1,
        imiscon_fetch_err = 2'd2,
        imiscon_pma_viol  = 2'd3
    } imiscon_e;

    typedef enum logic [4:0] {
        exc_iaccess   = 5'd1,
        exc_illegal   = 5'd2,
        exc_ebreak    = 5'd3,
        exc_ladd_miss = 5'd4,
        exc_laccess   = 5'd5,
        exc_sadd_miss = 5'd6,
        exc_saccess   = 5'd7,
        exc_ecall_m   = 5'd11
    } exc_code_e;

    // also the bit positions in mie and mip
    typedef enum logic [4:0] {
        int_msi = 5'd3,
        int_mti = 5'd7,
        int_mei = 5'd11
    } int_code_e;

    localparam logic [xlen-1:0] misa_value  = 32'h4000_1104; // rv32imc
    localparam logic [xlen-1:0] mstatus_mpp = 32'h0000_1800; // machine mode only

    localparam int mie_bit  = 3;
    localparam int mpie_bit = 7;

endpackage

// File: csr_cmd_if.sv
`timescale 1ns/100ps

interface csr_cmd_if;
    import csr_pkg::*;

    logic            wr_en;      // machine csr write this cycle
    csr_addr_e       wr_addr;    // also selects the read value
    csr_class_e      wr_class;
    logic [xlen-1:0] wr_data;    // value after read-modify-write
    logic            mret;
    logic            trap_take;  // interrupt or exception entered
    logic            trap_int;
    logic [4:0]      trap_code;
    logic            exc_active;
    logic [xlen-1:0] tval;
    logic            commit;
    logic            execute;    // valid instruction, no pipeline restart
    logic            stall;

    modport decode (output wr_en, wr_addr, wr_class, wr_data, mret, trap_take, trap_int,
                    trap_code, exc_active, tval, commit, execute, stall);
    modport sink (input wr_en, wr_addr, wr_class, wr_data, mret, trap_take, trap_int,
                  trap_code, exc_active, tval, commit, execute, stall);
endinterface

// File: csr_decode.sv
`timescale 1ns/100ps

module csr_decode (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  logic                     hresp_i,
    input  csr_pkg::imiscon_e        imiscon_i,
    input  logic                     rstpp_i,
    input  logic                     interrupted_i,
    input  csr_pkg::unit_e           unit_i,
    input  logic [3:0]               function_i,
    input  logic [11:0]              payload_i,
    input  logic [csr_pkg::xlen-1:0] val_i,
    input  csr_pkg::int_code_e       int_code_i,
    input  logic [csr_pkg::xlen-1:0] regs_r_i,
    input  logic [csr_pkg::xlen-1:0] cnt_r_i,
    output logic [csr_pkg::xlen-1:0] csr_r_o,
    output logic                     exception_o,
    output logic                     treturn_o,
    csr_cmd_if.decode                cmd
);
    import csr_pkg::*;

    logic is_csr, is_lsu, pma_viol, sys_fun, machine_csr;
    logic exc_misaligned, exc_ls_access, exc_iacc, exc_ill, exc_ecall, exc_ebrk;
    logic exception, execute;
    csr_op_e   op;
    exc_code_e exc_code;

    assign is_csr      = unit_i == unit_csr;
    assign is_lsu      = unit_i == unit_lsu;
    assign pma_viol    = imiscon_i == imiscon_pma_viol;
    assign sys_fun     = is_csr & (function_i[2:0] == 3'b000);
    assign machine_csr = payload_i[6:5] == 2'b11;
    assign op          = csr_op_e'(function_i[1:0]);

    // exception sources
    assign exc_misaligned = is_lsu & ((function_i[1] & |val_i[1:0]) | (function_i[0] & val_i[0]));
    assign exc_ls_access  = is_lsu & (hresp_i | pma_viol);
    assign exc_iacc       = (imiscon_i == imiscon_fetch_err) | (pma_viol & ~is_lsu);
    assign exc_ill        = imiscon_i == imiscon_illegal;
    assign exc_ecall      = sys_fun & (payload_i[10:9] == fun_ecall);
    assign exc_ebrk       = sys_fun & (payload_i[10:9] == fun_ebreak);
    assign exception      = exc_misaligned | exc_ls_access | exc_iacc | exc_ill
                          | exc_ecall | exc_ebrk;

    always_comb begin
        if (exc_iacc)            exc_code = exc_iaccess;
        else if (exc_ill)        exc_code = exc_illegal;
        else if (exc_ecall)      exc_code = exc_ecall_m;
        else if (exc_ebrk)       exc_code = exc_ebreak;
        else if (exc_misaligned) exc_code = function_i[3] ? exc_sadd_miss : exc_ladd_miss;
        else                     exc_code = function_i[3] ? exc_saccess : exc_laccess;
    end

    assign csr_r_o = regs_r_i | cnt_r_i; // each block reads zero outside its range

    // read-modify-write value
    always_comb begin
        case (op)
            op_rw:   cmd.wr_data = val_i;
            op_rs:   cmd.wr_data = csr_r_o | val_i;
            op_rc:   cmd.wr_data = csr_r_o & ~val_i;
            default: cmd.wr_data = csr_r_o;
        endcase
    end

    assign execute = ((unit_i != unit_none) | exc_iacc | exc_ill) & ~rstpp_i;

    assign cmd.wr_en      = is_csr & (op != op_none) & machine_csr & ~flush_i;
    assign cmd.wr_addr    = csr_addr_e'(payload_i[4:0]);
    assign cmd.wr_class   = csr_class_e'(payload_i[8:7]);
    assign cmd.mret       = sys_fun & machine_csr & (payload_i[8:7] == class_std)
                          & (payload_i[10:9] == fun_ret) & ~flush_i;
    assign cmd.trap_take  = interrupted_i | (exception & execute);
    assign cmd.trap_int   = interrupted_i;
    assign cmd.trap_code  = interrupted_i ? int_code_i : exc_code;
    assign cmd.exc_active = exception & execute & ~interrupted_i;
    assign cmd.tval       = val_i;
    assign cmd.commit     = (unit_i != unit_none) & ~stall_i & ~flush_i;
    assign cmd.execute    = execute;
    assign cmd.stall      = stall_i;

    assign exception_o = exception;
    assign treturn_o   = cmd.mret;

    // a system function never carries a csr op
    assert property (@(posedge clk_i) disable iff (reset_i) !(cmd.wr_en && cmd.mret))
        else $error("csr write and mret in the same cycle");

endmodule

// File: csr_trap_vector.sv
`timescale 1ns/100ps

module csr_trap_vector (
    input  logic [csr_pkg::xlen-1:0] mie_i,
    input  logic [csr_pkg::xlen-1:0] mip_i,
    input  logic                     mstatus_mie_i,
    input  logic [csr_pkg::xlen-1:0] mtvec_i,
    output logic                     int_pending_o,
    output csr_pkg::int_code_e       int_code_o,
    output logic [csr_pkg::xlen-1:0] exc_trap_o,
    output logic [csr_pkg::xlen-1:0] int_trap_o
);
    import csr_pkg::*;

    logic [xlen-1:0] active;
    logic [xlen-1:0] vector_offset;

    assign active        = mie_i & mip_i;
    assign int_pending_o = |active & mstatus_mie_i; // global enable from mstatus

    // fixed priority, external first
    always_comb begin
        if (active[int_mei]) begin
            int_code_o = int_mei;
        end else if (active[int_msi]) begin
            int_code_o = int_msi;
        end else begin
            int_code_o = int_mti;
        end
    end

    assign exc_trap_o    = {mtvec_i[xlen-1:2], 2'b00};
    assign vector_offset = {{(xlen-7){1'b0}}, int_code_o, 2'b00}; // 4 * code

    // vectored mode adds the offset, direct mode shares one entry
    assign int_trap_o = mtvec_i[0] ? exc_trap_o + vector_offset : exc_trap_o;

endmodule

// File: csr_regs.sv
`timescale 1ns/100ps

module csr_regs #(
    parameter logic [csr_pkg::xlen-1:0] BOOT_ADDR = '0
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     irq_meip_i,
    input  logic                     irq_mtip_i,
    input  logic                     irq_msip_i,
    input  logic [csr_pkg::xlen-1:0] newrst_point_i,
    input  logic                     interrupted_i,
    csr_cmd_if.sink                  cmd,
    output logic [csr_pkg::xlen-1:0] r_o,
    output logic [csr_pkg::xlen-1:0] mie_o,
    output logic [csr_pkg::xlen-1:0] mip_o,
    output logic                     mstatus_mie_o,
    output logic [csr_pkg::xlen-1:0] mtvec_o,
    output logic [csr_pkg::xlen-1:0] mepc_o,
    output logic [csr_pkg::xlen-1:0] rst_point_o
);
    import csr_pkg::*;

    localparam logic [xlen-1:0] irq_mask = (xlen'(1) << int_mei) | (xlen'(1) << int_mti)
                                         | (xlen'(1) << int_msi);

    logic            status_mie, status_mpie;
    logic [xlen-1:0] mie_q, mip_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q;
    logic [xlen-1:0] rst_point_q;
    logic [xlen-1:0] mip_next;
    logic [xlen-1:0] status_rd;
    logic            std_wr;

    assign std_wr = cmd.wr_en & (cmd.wr_class == class_std);

    always_comb begin
        mip_next          = '0;
        mip_next[int_mei] = irq_meip_i;
        mip_next[int_mti] = irq_mtip_i;
        mip_next[int_msi] = irq_msip_i;
    end

    // mstatus: trap entry wins over mret, mret over a csr write
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
        end else if (cmd.trap_take) begin
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
        end else if (cmd.mret) begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
        end else if (std_wr && cmd.wr_addr == mcsr_status) begin
            status_mie  <= cmd.wr_data[mie_bit];
            status_mpie <= cmd.wr_data[mpie_bit];
        end
    end

    // trap state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else begin
            if (cmd.trap_take) begin
                mepc_q   <= rst_point_q; // address of the trapped instruction
                mcause_q <= {cmd.trap_int, {(xlen-6){1'b0}}, cmd.trap_code};
            end else begin
                if (std_wr && cmd.wr_addr == mcsr_epc) mepc_q <= cmd.wr_data;
                if (std_wr && cmd.wr_addr == mcsr_cause) mcause_q <= cmd.wr_data;
            end
            if (cmd.exc_active) begin
                mtval_q <= cmd.tval;
            end else if (std_wr && cmd.wr_addr == mcsr_tval) begin
                mtval_q <= cmd.wr_data;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mie_q      <= '0;
            mip_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else begin
            mip_q <= mip_next; // sampled every cycle
            if (std_wr && cmd.wr_addr == mcsr_ie) mie_q <= cmd.wr_data & irq_mask;
            if (std_wr && cmd.wr_addr == mcsr_tvec) begin
                mtvec_q <= {cmd.wr_data[xlen-1:2], 1'b0, cmd.wr_data[0]};
            end
            if (std_wr && cmd.wr_addr == mcsr_scratch) mscratch_q <= cmd.wr_data;
        end
    end

    // reset point follows the executing instruction
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rst_point_q <= BOOT_ADDR;
        end else if ((cmd.execute && !cmd.stall) || interrupted_i) begin
            rst_point_q <= newrst_point_i;
        end
    end

    always_comb begin
        status_rd           = mstatus_mpp;
        status_rd[mie_bit]  = status_mie;
        status_rd[mpie_bit] = status_mpie;
    end

    always_comb begin
        case (cmd.wr_addr)
            mcsr_status:  r_o = status_rd;
            mcsr_isa:     r_o = misa_value;
            mcsr_ie:      r_o = mie_q;
            mcsr_tvec:    r_o = mtvec_q;
            mcsr_scratch: r_o = mscratch_q;
            mcsr_epc:     r_o = mepc_q;
            mcsr_cause:   r_o = mcause_q;
            mcsr_tval:    r_o = mtval_q;
            mcsr_ip:      r_o = mip_q;
            mcsr_hartid:  r_o = '0; // single hart
            default:      r_o = '0;
        endcase
    end

    assign mie_o         = mie_q;
    assign mip_o         = mip_q;
    assign mstatus_mie_o = status_mie;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;
    assign rst_point_o   = rst_point_q;

    // only direct and vectored modes exist
    assert property (@(posedge clk_i) disable iff (reset_i) mtvec_q[1] == 1'b0)
        else $error("mtvec mode bit 1 set");

endmodule

// File: csr_counters.sv
`timescale 1ns/100ps

module csr_counters (
    input  logic                     clk_i,
    input  logic                     reset_i,
    csr_cmd_if.sink                  cmd,
    output logic [csr_pkg::xlen-1:0] r_o
);
    import csr_pkg::*;

    logic [63:0] mcycle_q, minstret_q;
    logic [63:0] mcycle_next, minstret_next;
    logic        cnt_wr, cycle_wr;

    assign cnt_wr   = cmd.wr_en & (cmd.wr_class == class_counter);
    assign cycle_wr = cnt_wr & (cmd.wr_addr == mcsr_cycle || cmd.wr_addr == mcsr_cycleh);

    // a write replaces the addressed half, the other half still counts
    always_comb begin
        mcycle_next   = mcycle_q + 64'd1;
        minstret_next = cmd.commit ? minstret_q + 64'd1 : minstret_q;
        if (cnt_wr) begin
            case (cmd.wr_addr)
                mcsr_cycle:    mcycle_next[31:0]    = cmd.wr_data;
                mcsr_cycleh:   mcycle_next[63:32]   = cmd.wr_data;
                mcsr_instret:  minstret_next[31:0]  = cmd.wr_data;
                mcsr_instreth: minstret_next[63:32] = cmd.wr_data;
                default:       ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= mcycle_next;
            minstret_q <= minstret_next;
        end
    end

    always_comb begin
        case (cmd.wr_addr)
            mcsr_cycle:    r_o = mcycle_q[31:0];
            mcsr_cycleh:   r_o = mcycle_q[63:32];
            mcsr_instret:  r_o = minstret_q[31:0];
            mcsr_instreth: r_o = minstret_q[63:32];
            default:       r_o = '0;
        endcase
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
                     !cycle_wr |=> mcycle_q == $past(mcycle_q) + 64'd1)
        else $error("mcycle did not advance by one");

endmodule

// File: csr_unit.sv
`timescale 1ns/100ps

module csr_unit #(
    parameter logic [csr_pkg::xlen-1:0] BOOT_ADDR = '0
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  logic                     irq_meip_i,
    input  logic                     irq_mtip_i,
    input  logic                     irq_msip_i,
    input  logic                     hresp_i,
    input  csr_pkg::imiscon_e        imiscon_i,
    input  logic                     rstpp_i,
    input  logic [csr_pkg::xlen-1:0] newrst_point_i,
    input  logic                     interrupted_i,
    input  csr_pkg::unit_e           unit_i,
    input  logic [3:0]               function_i,
    input  logic [11:0]              payload_i,
    input  logic [csr_pkg::xlen-1:0] val_i,
    output logic [csr_pkg::xlen-1:0] csr_r_o,
    output logic [csr_pkg::xlen-1:0] exc_trap_o,
    output logic [csr_pkg::xlen-1:0] int_trap_o,
    output logic [csr_pkg::xlen-1:0] rst_point_o,
    output logic [csr_pkg::xlen-1:0] mepc_o,
    output logic                     treturn_o,
    output logic                     int_pending_o,
    output logic                     exception_o
);
    import csr_pkg::*;

    logic [xlen-1:0] regs_r, cnt_r, mie, mip, mtvec;
    logic            mstatus_mie;
    int_code_e       int_code;

    csr_cmd_if cmd ();

    csr_decode m_decode (
        .clk_i, .reset_i, .stall_i, .flush_i, .hresp_i, .imiscon_i, .rstpp_i,
        .interrupted_i, .unit_i, .function_i, .payload_i, .val_i,
        .int_code_i(int_code), .regs_r_i(regs_r), .cnt_r_i(cnt_r),
        .csr_r_o, .exception_o, .treturn_o, .cmd(cmd.decode)
    );

    csr_trap_vector m_trap_vector (
        .mie_i(mie), .mip_i(mip), .mstatus_mie_i(mstatus_mie), .mtvec_i(mtvec),
        .int_pending_o, .int_code_o(int_code), .exc_trap_o, .int_trap_o
    );

    csr_regs #(.BOOT_ADDR(BOOT_ADDR)) m_regs (
        .clk_i, .reset_i, .irq_meip_i, .irq_mtip_i, .irq_msip_i, .newrst_point_i,
        .interrupted_i, .cmd(cmd.sink), .r_o(regs_r), .mie_o(mie), .mip_o(mip),
        .mstatus_mie_o(mstatus_mie), .mtvec_o(mtvec), .mepc_o, .rst_point_o
    );

    csr_counters m_counters (
        .clk_i, .reset_i, .cmd(cmd.sink), .r_o(cnt_r)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int reset_cycles = 3
) (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o; // 10 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #1 reset_o = 1'b0; // released together with the other inputs
    end
endmodule

// File: csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [31:0] boot_addr   = 32'h0000_0080;
    localparam int          test_cycles = 200; // bound on the whole sequence
    localparam int          max_cycles  = 2 * test_cycles;

    logic        clk_i, reset_i, stall_i, flush_i, hresp_i, rstpp_i, interrupted_i;
    logic        irq_meip_i, irq_mtip_i, irq_msip_i;
    imiscon_e    imiscon_i;
    unit_e       unit_i;
    logic [3:0]  function_i;
    logic [11:0] payload_i;
    logic [31:0] val_i, newrst_point_i;
    logic [31:0] csr_r_o, exc_trap_o, int_trap_o, rst_point_o, mepc_o;
    logic        treturn_o, int_pending_o, exception_o;

    logic        chk_r, chk_flags, chk_rst, chk_itrap, chk_etrap, chk_epc;
    logic [31:0] exp_r, exp_rst, exp_itrap, exp_etrap, exp_epc;
    logic        exp_pend, exp_exc, exp_ret;
    logic [31:0] rst_model, rng_state, data, base, epc;
    int          errors, checks;
    int          cycles = 0;

    tb_clock m_clock (.clk_o(clk_i), .reset_o(reset_i));

    csr_unit #(.BOOT_ADDR(boot_addr)) UUT (.*);

    // outputs are sampled mid-cycle, well away from both input and register updates
    assert property (@(negedge clk_i) disable iff (reset_i) chk_r |-> csr_r_o == exp_r)
        else report_value("csr_r_o", csr_r_o, exp_r);
    assert property (@(negedge clk_i) disable iff (reset_i)
                     chk_flags |-> int_pending_o == exp_pend)
        else report_value("int_pending_o", 32'(int_pending_o), 32'(exp_pend));
    assert property (@(negedge clk_i) disable iff (reset_i)
                     chk_flags |-> exception_o == exp_exc)
        else report_value("exception_o", 32'(exception_o), 32'(exp_exc));
    assert property (@(negedge clk_i) disable iff (reset_i) chk_flags |-> treturn_o == exp_ret)
        else report_value("treturn_o", 32'(treturn_o), 32'(exp_ret));
    assert property (@(negedge clk_i) disable iff (reset_i) chk_rst |-> rst_point_o == exp_rst)
        else report_value("rst_point_o", rst_point_o, exp_rst);
    assert property (@(negedge clk_i) disable iff (reset_i)
                     chk_itrap |-> int_trap_o == exp_itrap)
        else report_value("int_trap_o", int_trap_o, exp_itrap);
    assert property (@(negedge clk_i) disable iff (reset_i)
                     chk_etrap |-> exc_trap_o == exp_etrap)
        else report_value("exc_trap_o", exc_trap_o, exp_etrap);
    assert property (@(negedge clk_i) disable iff (reset_i) chk_epc |-> mepc_o == exp_epc)
        else report_value("mepc_o", mepc_o, exp_epc);

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: test sequence did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic report_value(string name, logic [31:0] got, logic [31:0] expected);
        errors++;
        $display("FAILED %s: got %h expected %h", name, got, expected);
    endtask

    function logic [31:0] rand_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223; // lcg step
        return rng_state;
    endfunction

    task automatic clear_inputs();
        unit_i         = unit_none;
        function_i     = '0;
        payload_i      = '0;
        val_i          = '0;
        imiscon_i      = imiscon_none;
        hresp_i        = 1'b0;
        rstpp_i        = 1'b0;
        interrupted_i  = 1'b0;
        stall_i        = 1'b0;
        flush_i        = 1'b0;
        newrst_point_i = rst_model + 32'd4; // next instruction address
        chk_r          = 1'b0;
        chk_flags      = 1'b0;
        chk_rst        = 1'b0;
        chk_itrap      = 1'b0;
        chk_etrap      = 1'b0;
        chk_epc        = 1'b0;
    endtask

    task automatic next_cycle();
        // reset point loads on an executing unstalled instruction or an interrupt
        if ((unit_i != unit_none && !stall_i) || interrupted_i) rst_model = newrst_point_i;
        @(posedge clk_i);
        #1;
        clear_inputs();
    endtask

    task automatic expect_flags(logic pend, logic exc, logic ret);
        chk_flags = 1'b1;
        exp_pend  = pend;
        exp_exc   = exc;
        exp_ret   = ret;
        checks += 3;
    endtask

    task automatic expect_mepc(logic [31:0] expected);
        chk_epc = 1'b1;
        exp_epc = expected;
        checks++;
    endtask

    task automatic issue_csr(csr_op_e op, csr_class_e cls, csr_addr_e addr, logic [31:0] wdata);
        unit_i     = unit_csr;
        function_i = {2'b00, op};
        payload_i  = {3'b000, cls, 2'b11, addr};
        val_i      = wdata;
        next_cycle();
    endtask

    task automatic read_expect(csr_addr_e addr, logic [31:0] expected);
        payload_i = {7'b0, addr}; // no instruction, read address only
        chk_r     = 1'b1;
        exp_r     = expected;
        checks++;
        next_cycle();
    endtask

    task automatic issue_alu(logic stall, logic flush);
        unit_i  = unit_alu;
        stall_i = stall;
        flush_i = flush;
        next_cycle();
    endtask

    task automatic exception_case(unit_e unit, logic [3:0] func, imiscon_e misc, logic hresp,
                                  logic [31:0] val, exc_code_e cause);
        logic [31:0] trap_pc;
        issue_alu(1'b0, 1'b0); // puts a known address into the reset point
        trap_pc    = rst_model;
        unit_i     = unit;
        function_i = func;
        imiscon_i  = misc;
        hresp_i    = hresp;
        val_i      = val;
        expect_flags(1'b0, 1'b1, 1'b0);
        chk_rst = 1'b1;
        exp_rst = trap_pc;
        checks++;
        next_cycle();
        read_expect(mcsr_cause, {27'b0, cause});
        expect_mepc(trap_pc);
        read_expect(mcsr_epc, trap_pc);
        read_expect(mcsr_tval, val);
    endtask

    initial begin
        rng_state  = 32'd36819;
        rst_model  = boot_addr;
        errors     = 0;
        checks     = 0;
        irq_meip_i = 1'b0;
        irq_mtip_i = 1'b0;
        irq_msip_i = 1'b0;
        clear_inputs();
        @(negedge reset_i);

        // reset values
        expect_flags(1'b0, 1'b0, 1'b0);
        chk_rst = 1'b1;
        exp_rst = boot_addr;
        checks++;
        expect_mepc('0);
        read_expect(mcsr_status, 32'h0000_1800);
        read_expect(mcsr_ie, '0);
        read_expect(mcsr_epc, '0);

        // read-modify-write on mscratch
        data = rand_word();
        issue_csr(op_rw, class_std, mcsr_scratch, data);
        read_expect(mcsr_scratch, data);
        base = rand_word();
        issue_csr(op_rs, class_std, mcsr_scratch, base);
        data = data | base;
        read_expect(mcsr_scratch, data);
        base = rand_word();
        issue_csr(op_rc, class_std, mcsr_scratch, base);
        data = data & ~base;
        read_expect(mcsr_scratch, data);
        read_expect(mcsr_isa, 32'h4000_1104);
        read_expect(mcsr_hartid, '0);

        // illegal beats misaligned, then ecall, then store access fault
        data = rand_word();
        data[1:0] = 2'b01;
        exception_case(unit_lsu, 4'b0010, imiscon_illegal, 1'b0, data, exc_illegal);
        exception_case(unit_csr, 4'b0000, imiscon_none, 1'b0, rand_word(), exc_ecall_m);
        exception_case(unit_lsu, 4'b1000, imiscon_none, 1'b1, rand_word(), exc_saccess);

        // timer interrupt with vectored and direct mtvec
        base = rand_word();
        base[1:0] = 2'b00;
        issue_csr(op_rw, class_std, mcsr_ie, 32'h0000_0080);
        issue_csr(op_rw, class_std, mcsr_tvec, base | 32'h1);
        issue_csr(op_rs, class_std, mcsr_status, 32'h0000_0008);
        irq_mtip_i = 1'b1;
        expect_flags(1'b0, 1'b0, 1'b0); // mip not sampled yet
        next_cycle();
        expect_flags(1'b1, 1'b0, 1'b0);
        chk_itrap = 1'b1;
        exp_itrap = base + 32'd28;
        chk_etrap = 1'b1;
        exp_etrap = base; // mode bit dropped
        checks += 2;
        next_cycle();
        issue_csr(op_rc, class_std, mcsr_tvec, 32'h0000_0001);
        chk_itrap = 1'b1;
        exp_itrap = base; // same as the exception address
        chk_etrap = 1'b1;
        exp_etrap = base;
        checks += 2;
        next_cycle();

        // interrupt entry then mret
        epc = rst_model;
        interrupted_i = 1'b1;
        expect_flags(1'b1, 1'b0, 1'b0);
        next_cycle();
        expect_flags(1'b0, 1'b0, 1'b0);
        read_expect(mcsr_status, 32'h0000_1880);
        read_expect(mcsr_cause, 32'h8000_0007);
        expect_mepc(epc);
        read_expect(mcsr_epc, epc);
        unit_i    = unit_csr;
        payload_i = 12'h460; // mret
        expect_flags(1'b0, 1'b0, 1'b1);
        next_cycle();
        expect_flags(1'b1, 1'b0, 1'b0);
        read_expect(mcsr_status, 32'h0000_1888);
        irq_mtip_i = 1'b0;

        // counters
        data = rand_word();
        issue_csr(op_rw, class_counter, mcsr_cycle, data);
        read_expect(mcsr_cycle, data);
        repeat (9) next_cycle();
        read_expect(mcsr_cycle, data + 32'd10);
        issue_csr(op_rw, class_counter, mcsr_instret, '0);
        repeat (5) issue_alu(1'b0, 1'b0);
        read_expect(mcsr_instret, 32'd5);
        repeat (3) issue_alu(1'b1, 1'b0); // stalled
        repeat (2) issue_alu(1'b0, 1'b1); // flushed
        read_expect(mcsr_instret, 32'd5);
        data = rand_word();
        issue_csr(op_rw, class_counter, mcsr_cycleh, data);
        read_expect(mcsr_cycleh, data);
        next_cycle();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule

// File: compile.f
csr_pkg.sv
csr_cmd_if.sv
csr_decode.sv
csr_trap_vector.sv
csr_regs.sv
csr_counters.sv
csr_unit.sv
tb_clock.sv
csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csr unit testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module csr_unit_tb -o csr_unit_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_unit_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    exit 1
fi
exit 0
